/* verilog/hackPkg.sv */
package hackPkg;

    // one machine word, used by every data path
    typedef logic [15:0] hackWord;

    // instruction address, the Hack pc width
    typedef logic [14:0] romAddr;

    // instruction field positions
    localparam int instrTypePos = 15;  // clear for an A-instruction
    localparam int aBitPos      = 12;  // y operand is M instead of A
    localparam int compLsb      = 6;   // zx nx zy ny f no from bit 11 down
    localparam int compWidth    = 6;
    localparam int destLsb      = 3;
    localparam int destAPos     = 5;
    localparam int destDPos     = 4;
    localparam int destMPos     = 3;
    localparam int jumpLsb      = 0;
    localparam int jltPos       = 2;
    localparam int jeqPos       = 1;
    localparam int jgtPos       = 0;

    // jump field codes, lt eq gt from msb down
    localparam logic [2:0] jmpNone = 3'b000;
    localparam logic [2:0] jmpGt   = 3'b001;
    localparam logic [2:0] jmpEq   = 3'b010;
    localparam logic [2:0] jmpGe   = 3'b011;
    localparam logic [2:0] jmpLt   = 3'b100;
    localparam logic [2:0] jmpNe   = 3'b101;
    localparam logic [2:0] jmpLe   = 3'b110;
    localparam logic [2:0] jmpAll  = 3'b111;

    // ALU controls in instruction order
    typedef struct packed {
        logic zx;
        logic nx;
        logic zy;
        logic ny;
        logic f;
        logic no;
    } aluCtrl;

endpackage

/* verilog/hackMemIf.sv */
`timescale 1ns/1ps

// data memory port of the CPU
interface hackMemIf import hackPkg::*; ();

    hackWord addressM;  // from the A register
    hackWord outM;      // ALU result
    logic    writeM;    // store strobe, sampled at the rising edge
    hackWord inM;       // async read of addressM

    modport cpu (
        output addressM,
        output outM,
        output writeM,
        input  inM
    );

    modport mem (
        input  addressM,
        input  outM,
        input  writeM,
        output inM
    );

endinterface

/* verilog/hackAlu.sv */
`timescale 1ns/1ps

module hackAlu import hackPkg::*; (
    input  hackWord x,
    input  hackWord y,
    input  aluCtrl  ctrl,
    output hackWord out,
    output logic    zr,
    output logic    ng
);

    hackWord xOp;
    hackWord yOp;
    hackWord fOut;

    // x preset: zero first, then invert
    always_comb begin
        xOp = ctrl.zx ? '0 : x;
        if (ctrl.nx) begin
            xOp = ~xOp;
        end
    end

    // same for y
    always_comb begin
        yOp = ctrl.zy ? '0 : y;
        if (ctrl.ny) begin
            yOp = ~yOp;
        end
    end

    always_comb begin
        if (ctrl.f) begin
            fOut = xOp + yOp;  // wraps mod 2^16
        end else begin
            fOut = xOp & yOp;
        end
    end

    assign out = ctrl.no ? ~fOut : fOut;

    // status flags
    assign zr = (out == '0);
    assign ng = out[15];

endmodule

/* verilog/programCounter.sv */
`timescale 1ns/1ps

module programCounter import hackPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  logic   run,
    input  logic   load,
    input  romAddr target,
    output romAddr pc
);

    romAddr pcReg;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcReg <= '0;
        end else if (run) begin
            if (load) begin
                pcReg <= target;  // taken jump
            end else begin
                pcReg <= pcReg + romAddr'(1);  // wraps at the top
            end
        end
        // run low: hold
    end

    assign pc = pcReg;

endmodule

/* verilog/hackCpu.sv */
`timescale 1ns/1ps

module hackCpu import hackPkg::*; #(
    parameter int ramDepthLog2 = 10
) (
    input  logic         clk,
    input  logic         arstN,
    input  logic         run,
    input  hackWord      instr,
    hackMemIf.cpu        mem,
    output logic         jump,
    output romAddr       jumpTarget
);

    hackWord aReg;
    hackWord dReg;

    logic    isC;
    logic    aBit;
    aluCtrl  comp;
    logic [2:0] dest;
    logic [2:0] jmp;

    logic    writeA;
    logic    writeD;
    logic    writeMem;

    hackWord aluY;
    hackWord aluOut;
    logic    zr;
    logic    ng;
    logic    condMet;

    // decode
    assign isC  = instr[instrTypePos];
    assign aBit = instr[aBitPos];
    assign comp = aluCtrl'(instr[compLsb +: compWidth]);
    assign dest = instr[destLsb +: 3];
    assign jmp  = instr[jumpLsb +: 3];

    // destination strobes only fire for C-instructions while running
    assign writeA   = run && isC && dest[destAPos - destLsb];
    assign writeD   = run && isC && dest[destDPos - destLsb];
    assign writeMem = run && isC && dest[destMPos - destLsb];

    // y is M when the a bit is set
    assign aluY = aBit ? mem.inM : aReg;

    hackAlu alu (
        .x    (dReg),
        .y    (aluY),
        .ctrl (comp),
        .out  (aluOut),
        .zr   (zr),
        .ng   (ng)
    );

    // A register, loaded by A-instructions or as a destination
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            aReg <= '0;
        end else if (run && !isC) begin
            aReg <= {1'b0, instr[14:0]};
        end else if (writeA) begin
            aReg <= aluOut;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dReg <= '0;
        end else if (writeD) begin
            dReg <= aluOut;
        end
    end

    // jump rule: lt on ng, eq on zr, gt on neither
    assign condMet = (jmp[jltPos - jumpLsb] && ng)
                   || (jmp[jeqPos - jumpLsb] && zr)
                   || (jmp[jgtPos - jumpLsb] && !ng && !zr);

    assign jump       = run && isC && condMet;
    assign jumpTarget = aReg[14:0];

    // memory port
    assign mem.addressM = hackWord'(aReg[ramDepthLog2-1:0]);
    assign mem.outM     = aluOut;
    assign mem.writeM   = writeMem;

endmodule

/* verilog/instrRom.sv */
`timescale 1ns/1ps

module instrRom import hackPkg::*; #(
    parameter int romDepthLog2 = 10
) (
    input  logic    clk,
    input  logic    progWe,
    input  romAddr  progAddr,
    input  hackWord progData,
    input  romAddr  pc,
    output hackWord instr
);

    hackWord rom [2**romDepthLog2];

    // all zero words, i.e. @0
    initial begin
        for (int i = 0; i < 2**romDepthLog2; i++) begin
            rom[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (progWe) begin
            rom[progAddr[romDepthLog2-1:0]] <= progData;
        end
    end

    assign instr = rom[pc[romDepthLog2-1:0]];  // async fetch

endmodule

/* verilog/dataRam.sv */
`timescale 1ns/1ps

module dataRam import hackPkg::*; #(
    parameter int ramDepthLog2 = 10
) (
    input  logic    clk,
    hackMemIf.mem   mem,
    input  hackWord peekAddr,
    output hackWord peekData
);

    typedef logic [ramDepthLog2-1:0] ramIdx;

    hackWord ram [2**ramDepthLog2];

    ramIdx cpuIdx;
    ramIdx peekIdx;

    // both ports drop the address bits above the depth
    assign cpuIdx  = mem.addressM[ramDepthLog2-1:0];
    assign peekIdx = peekAddr[ramDepthLog2-1:0];

    // single write port, CPU side
    always_ff @(posedge clk) begin
        if (mem.writeM) begin
            ram[cpuIdx] <= mem.outM;
        end
    end

    assign mem.inM  = ram[cpuIdx];   // M operand
    assign peekData = ram[peekIdx];  // debug read

endmodule

/* verilog/hackComputer.sv */
`timescale 1ns/1ps

module hackComputer import hackPkg::*; #(
    parameter int romDepthLog2 = 10,
    parameter int ramDepthLog2 = 10
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    run,
    input  logic    progWe,
    input  romAddr  progAddr,
    input  hackWord progData,
    input  hackWord peekAddr,
    output hackWord peekData,
    output romAddr  pc
);

    hackWord instr;
    logic    jump;
    romAddr  jumpTarget;

    hackMemIf memBus ();

    hackCpu #(
        .ramDepthLog2 (ramDepthLog2)
    ) cpu (
        .clk        (clk),
        .arstN      (arstN),
        .run        (run),
        .instr      (instr),
        .mem        (memBus.cpu),
        .jump       (jump),
        .jumpTarget (jumpTarget)
    );

    programCounter pcUnit (
        .clk    (clk),
        .arstN  (arstN),
        .run    (run),
        .load   (jump),
        .target (jumpTarget),
        .pc     (pc)
    );

    // program store, loaded while run is low
    instrRom #(
        .romDepthLog2 (romDepthLog2)
    ) rom (
        .clk      (clk),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .pc       (pc),
        .instr    (instr)
    );

    dataRam #(
        .ramDepthLog2 (ramDepthLog2)
    ) ram (
        .clk      (clk),
        .mem      (memBus.mem),
        .peekAddr (peekAddr),
        .peekData (peekData)
    );

endmodule

/* test/hackComputer_chk.sv */
`timescale 1ns/1ps

module hackComputerChk import hackPkg::*; (
    input logic    clk,
    input logic    arstN,
    input logic    run,
    input logic    writeM,
    input romAddr  pc,
    input hackWord instr
);

    // nothing stored while stopped
    noWriteWhenStopped: assert property (
        @(posedge clk) disable iff (!arstN) !run |-> !writeM
    ) else $error("writeM high while run is low");

    // first edge after reset release, held by run low
    pcZeroAfterReset: assert property (
        @(posedge clk) ($rose(arstN) && !run) |-> (pc == '0)
    ) else $error("pc not zero after reset release");

    noWriteOnAInstr: assert property (
        @(posedge clk) disable iff (!arstN) !instr[instrTypePos] |-> !writeM
    ) else $error("writeM high on an A-instruction");

endmodule

bind hackComputer hackComputerChk chk (
    .clk    (clk),
    .arstN  (arstN),
    .run    (run),
    .writeM (memBus.writeM),
    .pc     (pc),
    .instr  (instr)
);

/* test/tbHackComputer.sv */
`timescale 1ns/1ps

module tbHackComputer import hackPkg::*; ();

    localparam int maxCycles = 4000;  // about twice the total test length
    localparam int sumHalt   = 17;    // self-loop address of the sum program

    localparam logic [2:0] dstNone = 3'b000;
    localparam logic [2:0] dstM    = 3'(1 << (destMPos - destLsb));
    localparam logic [2:0] dstD    = 3'(1 << (destDPos - destLsb));

    // comp codes, zx nx zy ny f no
    localparam logic [5:0] cZero    = 6'b101010;
    localparam logic [5:0] cOne     = 6'b111111;
    localparam logic [5:0] cMinus1  = 6'b111010;
    localparam logic [5:0] cD       = 6'b001100;
    localparam logic [5:0] cA       = 6'b110000;
    localparam logic [5:0] cNotA    = 6'b110001;
    localparam logic [5:0] cNegA    = 6'b110011;
    localparam logic [5:0] cAminus1 = 6'b110010;
    localparam logic [5:0] cDplusA  = 6'b000010;

    // the 18 standard comp codes, same order as opResult
    localparam logic [5:0] compTable [18] = '{
        6'b101010, 6'b111111, 6'b111010, 6'b001100, 6'b110000, 6'b001101,
        6'b110001, 6'b001111, 6'b110011, 6'b011111, 6'b110111, 6'b001110,
        6'b110010, 6'b000010, 6'b010011, 6'b000111, 6'b000000, 6'b010101
    };

    logic    clk;
    logic    arstN;
    logic    run;
    logic    progWe;
    romAddr  progAddr;
    hackWord progData;
    hackWord peekAddr;
    hackWord peekData;
    romAddr  pc;

    hackWord prog [$];  // program being built
    int      errCount   = 0;
    int      cycleCount = 0;

    hackComputer #(
        .romDepthLog2 (10),
        .ramDepthLog2 (10)
    ) uut (
        .clk      (clk),
        .arstN    (arstN),
        .run      (run),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .peekAddr (peekAddr),
        .peekData (peekData),
        .pc       (pc)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("timeout: tests did not finish within %0d cycles", maxCycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    function automatic hackWord encA(input int value);
        return {1'b0, value[14:0]};
    endfunction

    function automatic hackWord encC(input logic a, input logic [5:0] comp,
                                     input logic [2:0] dst, input logic [2:0] jmp);
        hackWord w;
        w = 16'hE000;  // C-instruction prefix
        w[aBitPos] = a;
        w[compLsb +: compWidth] = comp;
        w[destLsb +: 3] = dst;
        w[jumpLsb +: 3] = jmp;
        return w;
    endfunction

    // what each comp code means, x is D and y is A
    function automatic hackWord opResult(input int idx, input hackWord x, input hackWord y);
        case (idx)
            0:       return '0;
            1:       return 16'd1;
            2:       return 16'hffff;
            3:       return x;
            4:       return y;
            5:       return ~x;
            6:       return ~y;
            7:       return -x;
            8:       return -y;
            9:       return x + 16'd1;
            10:      return y + 16'd1;
            11:      return x - 16'd1;
            12:      return y - 16'd1;
            13:      return x + y;
            14:      return x - y;
            15:      return y - x;
            16:      return x & y;
            default: return x | y;
        endcase
    endfunction

    // @k then 0;JMP, loops at k
    task automatic addHalt();
        prog.push_back(encA(prog.size() + 1));
        prog.push_back(encC(1'b0, cZero, dstNone, jmpAll));
    endtask

    task automatic resetDut();
        @(posedge clk);
        run   <= 1'b0;
        arstN <= 1'b0;
        repeat (4) @(posedge clk);
        arstN <= 1'b1;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            progWe   <= 1'b1;
            progAddr <= romAddr'(i);
            progData <= prog[i];
        end
        @(posedge clk);
        progWe <= 1'b0;
    endtask

    task automatic runFor(input int n);
        @(posedge clk);
        run <= 1'b1;
        repeat (n) @(posedge clk);
        run <= 1'b0;  // exactly n instructions executed
    endtask

    task automatic peekCheck(input string name, input int addr, input hackWord expected);
        @(posedge clk);
        peekAddr <= hackWord'(addr);
        @(negedge clk);
        if (peekData !== expected) begin
            errCount++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, peekData);
        end
    endtask

    task automatic checkPc(input string name, input romAddr expected);
        @(negedge clk);
        if (pc !== expected) begin
            errCount++;
            $display("[ERROR] %s: expected pc %0d, actual %0d", name, expected, pc);
        end
    endtask

    // sum n down to 1 into RAM[400], counter in RAM[401]
    task automatic buildSumLoop(input int n);
        prog.delete();
        prog.push_back(encA(n));
        prog.push_back(encC(1'b0, cA, dstD, jmpNone));
        prog.push_back(encA(401));
        prog.push_back(encC(1'b0, cD, dstM, jmpNone));
        prog.push_back(encA(400));
        prog.push_back(encC(1'b0, cZero, dstM, jmpNone));
        prog.push_back(encA(401));                              // loop top at 6
        prog.push_back(encC(1'b1, cA, dstD, jmpNone));          // D=M
        prog.push_back(encA(16));
        prog.push_back(encC(1'b0, cD, dstNone, jmpEq));         // done when counter is 0
        prog.push_back(encA(400));
        prog.push_back(encC(1'b1, cDplusA, dstM, jmpNone));     // M=D+M
        prog.push_back(encA(401));
        prog.push_back(encC(1'b1, cAminus1, dstM, jmpNone));    // M=M-1
        prog.push_back(encA(6));
        prog.push_back(encC(1'b0, cZero, dstNone, jmpAll));
        addHalt();
    endtask

    task automatic testAluOps();
        hackWord xVals [18];
        hackWord yVals [18];
        prog.delete();
        for (int i = 0; i < 18; i++) begin
            xVals[i] = hackWord'($urandom % 32768);
            yVals[i] = hackWord'($urandom % 32768);
            prog.push_back(encA(int'(xVals[i])));
            prog.push_back(encC(1'b0, cA, dstD, jmpNone));
            prog.push_back(encA(int'(yVals[i])));
            prog.push_back(encC(1'b0, compTable[i], dstD, jmpNone));
            prog.push_back(encA(100 + i));
            prog.push_back(encC(1'b0, cD, dstM, jmpNone));
        end
        addHalt();
        resetDut();
        loadProgram();
        runFor(prog.size() + 4);
        for (int i = 0; i < 18; i++) begin
            peekCheck($sformatf("alu op %0d", i), 100 + i, opResult(i, xVals[i], yVals[i]));
        end
    endtask

    task automatic testMemOperand();
        hackWord r;
        hackWord d;
        r = hackWord'($urandom % 32768);
        d = hackWord'($urandom % 32768);
        prog.delete();
        prog.push_back(encA(int'(r)));
        prog.push_back(encC(1'b0, cA, dstD, jmpNone));
        prog.push_back(encA(200));
        prog.push_back(encC(1'b0, cD, dstM, jmpNone));
        prog.push_back(encA(int'(d)));
        prog.push_back(encC(1'b0, cNotA, dstD, jmpNone));  // top bit set, so the sum can wrap
        prog.push_back(encA(200));
        prog.push_back(encC(1'b1, cDplusA, dstD, jmpNone));
        prog.push_back(encA(201));
        prog.push_back(encC(1'b0, cD, dstM, jmpNone));
        addHalt();
        resetDut();
        loadProgram();
        runFor(prog.size() + 4);
        peekCheck("memory operand", 201, r + ~d);
    endtask

    task automatic testJumps();
        hackWord mag;
        logic    taken;
        int      resAddr;
        string   signName;
        for (int s = 0; s < 3; s++) begin  // negative, zero, positive D
            for (int j = 0; j < 8; j++) begin
                mag = hackWord'($urandom % 32767 + 1);
                resAddr = 300 + s * 8 + j;
                prog.delete();
                prog.push_back(encA(int'(mag)));
                if (s == 0) begin
                    signName = "neg";
                    prog.push_back(encC(1'b0, cNegA, dstD, jmpNone));
                end else if (s == 1) begin
                    signName = "zero";
                    prog.push_back(encC(1'b0, cZero, dstD, jmpNone));
                end else begin
                    signName = "pos";
                    prog.push_back(encC(1'b0, cA, dstD, jmpNone));
                end
                prog.push_back(encA(8));
                prog.push_back(encC(1'b0, cD, dstNone, 3'(j)));
                prog.push_back(encA(resAddr));                      // skipped path
                prog.push_back(encC(1'b0, cMinus1, dstM, jmpNone));
                prog.push_back(encA(11));
                prog.push_back(encC(1'b0, cZero, dstNone, jmpAll));
                prog.push_back(encA(resAddr));                      // taken path at 8
                prog.push_back(encC(1'b0, cOne, dstM, jmpNone));
                addHalt();
                taken = (j[2] && s == 0) || (j[1] && s == 1) || (j[0] && s == 2);
                resetDut();
                loadProgram();
                runFor(16);
                peekCheck($sformatf("jump %s code %b", signName, 3'(j)), resAddr,
                          taken ? 16'h0001 : 16'hffff);
            end
        end
    endtask

    task automatic testSumLoop();
        int n;
        n = $urandom % 30 + 1;
        buildSumLoop(n);
        resetDut();
        loadProgram();
        runFor(10 * n + 20);
        peekCheck("sum loop", 400, hackWord'(n * (n + 1) / 2));
        checkPc("sum loop pc", romAddr'(sumHalt));
    endtask

    task automatic testRunHold();
        int      n;
        romAddr  pcHeld;
        hackWord sumHeld;
        n = $urandom % 11 + 20;  // long enough that 100 cycles stops mid-loop
        buildSumLoop(n);
        resetDut();
        loadProgram();
        runFor(100);
        // 6 setup, 9 passes and 4 into the tenth, stopped before @400
        pcHeld  = romAddr'(10);
        sumHeld = hackWord'(9 * n - 36);  // n down to n-8
        checkPc("hold snapshot pc", pcHeld);
        peekCheck("hold snapshot", 400, sumHeld);
        repeat (20) @(posedge clk);
        checkPc("hold pc", pcHeld);
        peekCheck("hold ram", 400, sumHeld);
        runFor(300);  // resume
        peekCheck("resumed sum", 400, hackWord'(n * (n + 1) / 2));
        checkPc("resumed pc", romAddr'(sumHalt));
    endtask

    task automatic testReset();
        int n;
        n = $urandom % 30 + 1;
        buildSumLoop(n);
        resetDut();
        loadProgram();
        @(posedge clk);
        run <= 1'b1;
        repeat (10 * n + 20) @(posedge clk);
        arstN <= 1'b0;  // run still high, self-loop executing
        checkPc("reset pc", '0);
        peekCheck("reset keeps ram", 400, hackWord'(n * (n + 1) / 2));
        @(posedge clk);
        run <= 1'b0;
        @(posedge clk);
        arstN <= 1'b1;
        repeat (3) @(posedge clk);  // stays at 0 while run is low
        checkPc("pc after release", '0);
    endtask

    initial begin
        arstN    <= 1'b0;
        run      <= 1'b0;
        progWe   <= 1'b0;
        progAddr <= '0;
        progData <= '0;
        peekAddr <= '0;
        void'($urandom(32'h4076d50e));
        resetDut();
        testAluOps();
        testMemOperand();
        testJumps();
        testSumLoop();
        testRunHold();
        testReset();
        $display("tests done, errors: %0d", errCount);
        if (errCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
verilog/hackPkg.sv
verilog/hackMemIf.sv
verilog/hackAlu.sv
verilog/programCounter.sv
verilog/hackCpu.sv
verilog/instrRom.sv
verilog/dataRam.sv
verilog/hackComputer.sv
test/hackComputer_chk.sv
test/tbHackComputer.sv

/* Makefile */
SRCS := $(shell cat compile.f)

all: run

obj_dir/VtbHackComputer: compile.f $(SRCS)
	verilator --binary --timing --assert --top-module tbHackComputer -f compile.f

run: obj_dir/VtbHackComputer
	./obj_dir/VtbHackComputer > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
